// ==== sources.f ====
+incdir+verilog
verilog/fas_pkg.sv
verilog/fir_filter.sv
verilog/frame_assembler.sv
verilog/fft_stage.sv
verilog/fft_pipeline.sv
verilog/fas_top.sv
test/tb_fas.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the spectrum front end testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_fas \
    -f sources.f -o tb_fas; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_fas 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
if printf '%s\n' "$output" | grep -qx "Testbench passed"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== test/tb_fas.sv ====
// Testbench for the spectrum front end with reference FIR and FFT models
`timescale 1ns/1ps

module tb_fas
  import fas_pkg::*;
();

  localparam int N_PRIME   = FIR_TAPS - 1;            // Zeros that fill the history
  localparam int N_IMPULSE = 256;                     // Impulse plus zeros, sixteen frames
  localparam int N_RANDOM  = 320;
  localparam int N_BURST   = 96;
  localparam int N_SAT     = 64;
  localparam int N_SAMPLES = N_PRIME + N_IMPULSE + N_RANDOM + N_BURST + N_SAT;
  localparam longint WATCHDOG_NS = longint'(N_SAMPLES * 5 + 200) * 8;

  logic        clk, rst, data_valid, fir_valid, spectrum_valid;
  sample_t     data, fir_d;
  bin_vec_t    spectrum;
  sample_t     tb_hist [FIR_TAPS];                    // Index 0 is the newest sample
  frame_t      frame_buf;
  sample_t     fir_exp_q [$];
  int          fir_cyc_q [$];
  bin_vec_t    spec_exp_q [$];
  int          spec_cyc_q [$];
  int unsigned lcg_state;
  int          cyc, strobe_cnt, frame_slot, fir_seen, spec_seen, hi_clips, lo_clips;

  fas_top u_fas_top (
    .clk            (clk),
    .rst            (rst),
    .data_valid     (data_valid),
    .data           (data),
    .fir_valid      (fir_valid),
    .fir_d          (fir_d),
    .spectrum_valid (spectrum_valid),
    .spectrum       (spectrum)
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Reference models
  ////////////////////////////////////////////////////////////////////////////

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic int next_gap();
    return int'((lcg_next() >> 13) & 3);              // Zero to three idle cycles
  endfunction

  function automatic sample_t ref_fir(input sample_t h [FIR_TAPS]);
    longint acc;
    acc = 0;
    for (int k = 0; k < FIR_TAPS; k++) begin
      acc += longint'(h[k]) * longint'(FIR_COEFS[k]);
    end
    acc = (acc + 32768) >>> FIR_SHIFT;
    if (acc > 32767) acc = 32767;
    else if (acc < -32768) acc = -32768;
    return sample_t'(acc);
  endfunction

  // Keeps the low 18 bits as a signed value
  function automatic longint wrap_comp(input longint v);
    longint w;
    w = v & longint'(262143);
    return (w >= 131072) ? w - 262144 : w;
  endfunction

  function automatic bin_vec_t ref_fft(input frame_t f);
    longint   re [FFT_N];
    longint   im [FFT_N];
    longint   sr, si, dr, di;
    int       span, k, rev;
    bin_vec_t out;
    for (int i = 0; i < FFT_N; i++) begin
      re[i] = longint'(f[i]);
      im[i] = 0;
    end
    for (int s = 0; s < FFT_STAGES; s++) begin
      span = (FFT_N / 2) >> s;
      for (int j = 0; j < FFT_N; j++) begin
        if ((j & span) == 0) begin                    // Lower half of its group
          sr = (re[j] + re[j+span]) >>> 1;
          si = (im[j] + im[j+span]) >>> 1;
          dr = (re[j] - re[j+span]) >>> 1;
          di = (im[j] - im[j+span]) >>> 1;
          k  = (j % span) << s;
          re[j] = sr;
          im[j] = si;
          re[j+span] = wrap_comp((dr * TW_RE[k] - di * TW_IM[k]) >>> TW_SHIFT);
          im[j+span] = wrap_comp((dr * TW_IM[k] + di * TW_RE[k]) >>> TW_SHIFT);
        end
      end
    end
    for (int b = 0; b < FFT_N; b++) begin
      rev = 0;
      for (int i = 0; i < FFT_STAGES; i++) begin
        if (((b >> i) & 1) != 0) rev |= 1 << (FFT_STAGES - 1 - i);
      end
      out[b].re = fft_comp_t'(re[rev]);
      out[b].im = fft_comp_t'(im[rev]);
    end
    return out;
  endfunction

  function automatic int first_bad_bin(input bin_vec_t got, input bin_vec_t want);
    for (int b = 0; b < FFT_N; b++) begin
      if (got[b] !== want[b]) return b;
    end
    return 0;
  endfunction

  // Full-scale sample whose sign matches the coefficient it will meet
  function automatic sample_t sat_sample(input int i);
    sample_t v;
    v = (FIR_COEFS[FIR_TAPS - 1 - (i % FIR_TAPS)] < 0) ? -16'sd32767 : 16'sd32767;
    return (i >= FIR_TAPS) ? -v : v;
  endfunction

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic model_strobe(input sample_t v);
    sample_t expected;
    for (int k = FIR_TAPS - 1; k > 0; k--) begin
      tb_hist[k] = tb_hist[k-1];
    end
    tb_hist[0] = v;
    if (strobe_cnt < FIR_TAPS) strobe_cnt++;
    if (strobe_cnt == FIR_TAPS) begin
      expected = ref_fir(tb_hist);
      fir_exp_q.push_back(expected);
      fir_cyc_q.push_back(cyc + 2);                   // Visible at the second rising edge
      if (expected == 16'sh7fff) hi_clips++;
      if (expected == -16'sh8000) lo_clips++;
      frame_buf[frame_slot] = expected;
      frame_slot++;
      if (frame_slot == FFT_N) begin
        frame_slot = 0;
        spec_exp_q.push_back(ref_fft(frame_buf));
        spec_cyc_q.push_back(cyc + 7);                // Assembler and four FFT stages
      end
    end
  endtask

  // Called on a falling edge, returns on a falling edge
  task automatic send_sample(input sample_t v, input int gap);
    data_valid = 1'b1;
    data = v;
    model_strobe(v);
    @(negedge clk);
    data_valid = 1'b0;
    repeat (gap) @(negedge clk);
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    data_valid = 1'b0;
    data = '0;
    lcg_state = 32'd55177;
    for (int k = 0; k < FIR_TAPS; k++) begin
      tb_hist[k] = '0;
    end
    repeat (16) @(negedge clk);
    rst = 1'b0;
    repeat (4) @(negedge clk);
    for (int i = 0; i < N_PRIME; i++) send_sample('0, next_gap());
    for (int i = 0; i < N_IMPULSE; i++) begin
      send_sample((i == 0) ? 16'sd256 : 16'sd0, next_gap());
    end
    for (int i = 0; i < N_RANDOM; i++) send_sample(sample_t'(lcg_next() >> 16), next_gap());
    for (int i = 0; i < N_BURST; i++) send_sample(sample_t'(lcg_next() >> 16), 0);
    hi_clips = 0;
    lo_clips = 0;
    for (int i = 0; i < N_SAT; i++) send_sample(sat_sample(i), next_gap());
    assert (hi_clips > 0 && lo_clips > 0)
      else stop_with_failure("Saturation samples did not reach both clip limits");
    while (fir_exp_q.size() > 0 || spec_exp_q.size() > 0) @(negedge clk);
    repeat (8) @(negedge clk);                        // Catch any stray output pulse
    if (spec_seen == fir_seen / FFT_N && fir_seen == N_SAMPLES - N_PRIME) begin
      $display("Testbench passed");
      $finish;
    end else begin
      stop_with_failure($sformatf("Wrong output count: %0d filter outputs and %0d spectra",
                                  fir_seen, spec_seen));
    end
  end

  initial begin
    #(WATCHDOG_NS);
    stop_with_failure($sformatf("Timeout: the run did not finish within %0d ns", WATCHDOG_NS));
  end

  ////////////////////////////////////////////////////////////////////////////
  // Comparison
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : compare
    int bad;
    cyc = cyc + 1;
    if (!rst) begin
      assert (!$isunknown({fir_valid, spectrum_valid}))
        else stop_with_failure("A valid output is unknown after reset");
      if (fir_valid) begin
        assert (fir_exp_q.size() > 0)
          else stop_with_failure("fir_valid pulsed with no filter output expected");
        assert (fir_cyc_q[0] == cyc)
          else stop_with_failure($sformatf("Mismatch at time %0t: fir_valid in cycle %0d, expected %0d",
                                           $time, cyc, fir_cyc_q[0]));
        assert (fir_d === fir_exp_q[0])
          else stop_with_failure($sformatf("Mismatch at time %0t: fir_d is %0d, expected %0d",
                                           $time, fir_d, fir_exp_q[0]));
        void'(fir_exp_q.pop_front());
        void'(fir_cyc_q.pop_front());
        fir_seen++;
      end else if (fir_cyc_q.size() > 0) begin
        assert (fir_cyc_q[0] > cyc)
          else stop_with_failure("An expected fir_valid pulse never came");
      end
      if (spectrum_valid) begin
        assert (spec_exp_q.size() > 0)
          else stop_with_failure("spectrum_valid pulsed with no spectrum expected");
        bad = first_bad_bin(spectrum, spec_exp_q[0]);
        assert (spec_cyc_q[0] == cyc)
          else stop_with_failure($sformatf("Mismatch at time %0t: spectrum in cycle %0d, expected %0d",
                                           $time, cyc, spec_cyc_q[0]));
        assert (spectrum === spec_exp_q[0])
          else stop_with_failure($sformatf("Mismatch at time %0t: bin %0d is %0d,%0d, expected %0d,%0d",
                                           $time, bad, spectrum[bad].re, spectrum[bad].im,
                                           spec_exp_q[0][bad].re, spec_exp_q[0][bad].im));
        void'(spec_exp_q.pop_front());
        void'(spec_cyc_q.pop_front());
        spec_seen++;
      end else if (spec_cyc_q.size() > 0) begin
        assert (spec_cyc_q[0] > cyc)
          else stop_with_failure("An expected spectrum_valid pulse never came");
      end
    end
  end

endmodule

// ==== verilog/fas_top.sv ====
// Spectrum front end top level joining the FIR filter, frame assembler and FFT
`timescale 1ns/1ps

module fas_top
  import fas_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     data_valid,
  input  sample_t  data,
  output logic     fir_valid,
  output sample_t  fir_d,
  output logic     spectrum_valid,
  output bin_vec_t spectrum
);

  logic   frame_valid;                                // One-cycle pulse per complete frame
  frame_t frame;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  fir_filter u_fir_filter (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .data       (data),
    .fir_valid  (fir_valid),
    .fir_d      (fir_d)
  );

  frame_assembler u_frame_assembler (
    .clk         (clk),
    .rst         (rst),
    .fir_valid   (fir_valid),
    .fir_d       (fir_d),
    .frame_valid (frame_valid),
    .frame       (frame)
  );

  // Four cycles of latency, up to four frames in flight
  fft_pipeline u_fft_pipeline (
    .clk            (clk),
    .rst            (rst),
    .frame_valid    (frame_valid),
    .frame          (frame),
    .spectrum_valid (spectrum_valid),
    .spectrum       (spectrum)
  );

endmodule

// ==== verilog/fft_pipeline.sv ====
// 16-point FFT pipeline of four stages with natural-order output
`timescale 1ns/1ps

module fft_pipeline
  import fas_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     frame_valid,
  input  frame_t   frame,
  output logic     spectrum_valid,
  output bin_vec_t spectrum
);

  bin_vec_t              stage_bins  [FFT_STAGES+1];
  logic [FFT_STAGES:0]   stage_valid;

  // Reverses the low FFT_STAGES bits of a bin index
  function automatic int bit_rev(input int idx);
    int rev;
    rev = 0;
    for (int i = 0; i < FFT_STAGES; i++) begin
      rev = (rev << 1) | ((idx >> i) & 1);
    end
    return rev;
  endfunction

  // Real samples enter as the real part, sign extended into the guard bits
  for (genvar i = 0; i < FFT_N; i++) begin : g_load
    assign stage_bins[0][i] = '{re: fft_comp_t'(frame[i]), im: '0};
  end

  assign stage_valid[0] = frame_valid;

  for (genvar s = 0; s < FFT_STAGES; s++) begin : g_stage
    fft_stage #(
      .STAGE (s)
    ) u_fft_stage (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (stage_valid[s]),
      .in_bins   (stage_bins[s]),
      .out_valid (stage_valid[s+1]),
      .out_bins  (stage_bins[s+1])
    );
  end

  // DIF leaves bin k at the bit-reversed position
  for (genvar k = 0; k < FFT_N; k++) begin : g_reorder
    assign spectrum[k] = stage_bins[FFT_STAGES][bit_rev(k)];
  end

  assign spectrum_valid = stage_valid[FFT_STAGES];

  a_spectrum_known : assert property (
    @(posedge clk) disable iff (rst) spectrum_valid |-> !$isunknown(spectrum)
  );

endmodule

// ==== verilog/fft_stage.sv ====
// One registered radix-2 decimation-in-frequency stage with eight scaled butterflies
`timescale 1ns/1ps

module fft_stage
  import fas_pkg::*;
#(
  parameter int STAGE = 0
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  bin_vec_t in_bins,
  output logic     out_valid,
  output bin_vec_t out_bins
);

  localparam int SPAN = (FFT_N / 2) >> STAGE;         // Distance between butterfly inputs

  bin_vec_t nxt_bins;

  ////////////////////////////////////////////////////////////////////////////
  // Butterflies
  ////////////////////////////////////////////////////////////////////////////

  for (genvar b = 0; b < FFT_N / 2; b++) begin : g_bfly
    localparam int LO = (b / SPAN) * 2 * SPAN + (b % SPAN);
    localparam int HI = LO + SPAN;
    localparam int TW = (b % SPAN) << STAGE;          // Twiddle index, always below 8

    fft_comp_t                    a_re, a_im, b_re, b_im;
    logic signed [COMP_W:0]       sum_re, sum_im;
    logic signed [COMP_W:0]       dif_re, dif_im;
    fft_comp_t                    dif_re_h, dif_im_h;
    logic signed [COMP_W+TW_W:0]  prod_re, prod_im;

    assign a_re = in_bins[LO].re;
    assign a_im = in_bins[LO].im;
    assign b_re = in_bins[HI].re;
    assign b_im = in_bins[HI].im;

    assign sum_re = a_re + b_re;
    assign sum_im = a_im + b_im;
    assign dif_re = a_re - b_re;
    assign dif_im = a_im - b_im;

    // Dropping bit 0 is the arithmetic shift right by one
    assign dif_re_h = dif_re[COMP_W:1];
    assign dif_im_h = dif_im[COMP_W:1];

    assign prod_re = dif_re_h * TW_RE[TW] - dif_im_h * TW_IM[TW];
    assign prod_im = dif_re_h * TW_IM[TW] + dif_im_h * TW_RE[TW];

    // Upper position takes the halved sum
    assign nxt_bins[LO] = '{re: sum_re[COMP_W:1], im: sum_im[COMP_W:1]};

    // Shift by TW_SHIFT and truncate to the component width
    assign nxt_bins[HI] = '{
      re: prod_re[TW_SHIFT +: COMP_W],
      im: prod_im[TW_SHIFT +: COMP_W]
    };
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    out_bins <= nxt_bins;                             // Loaded every clock, qualified by out_valid
  end

endmodule

// ==== verilog/frame_assembler.sv ====
// Frame assembler that packs 16 consecutive filter outputs into one frame
`timescale 1ns/1ps

module frame_assembler
  import fas_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    fir_valid,
  input  sample_t fir_d,
  output logic    frame_valid,
  output frame_t  frame
);

  localparam int SLOT_W = $clog2(FFT_N);

  logic [SLOT_W-1:0] slot_cnt;                        // Next slot to be written

  ////////////////////////////////////////////////////////////////////////////
  // Slot counter and completion pulse
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      slot_cnt    <= '0;
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= fir_valid && (slot_cnt == SLOT_W'(FFT_N - 1));
      if (fir_valid) begin
        slot_cnt <= slot_cnt + 1'b1;                  // Wraps so frames never overlap
      end
    end
  end

  // The frame register is read directly by the FFT while frame_valid is high;
  // slot 0 is only overwritten by the next sample, one edge later at earliest
  always_ff @(posedge clk) begin
    if (fir_valid) begin
      frame[slot_cnt] <= fir_d;
    end
  end

  // Completion is caused by the last write of the frame, which wraps the slot counter
  a_frame_after_sample : assert property (
    @(posedge clk) disable iff (rst)
      frame_valid |-> $past(fir_valid) && (slot_cnt == '0)
  );

endmodule

// ==== verilog/fir_filter.sv ====
// 32-tap FIR low-pass filter with rounding, saturation and history fill tracking
`timescale 1ns/1ps

module fir_filter
  import fas_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    data_valid,
  input  sample_t data,
  output logic    fir_valid,
  output sample_t fir_d
);

  localparam int CNT_W = $clog2(FIR_TAPS + 1);

  // Clip limits of the sample range, expressed at accumulator width
  localparam fir_acc_t SAT_HI = (fir_acc_t'(1) <<< (SAMPLE_W - 1)) - 1;
  localparam fir_acc_t SAT_LO = -(fir_acc_t'(1) <<< (SAMPLE_W - 1));
  localparam fir_acc_t HALF_LSB = fir_acc_t'(1) <<< (FIR_SHIFT - 1);

  sample_t          hist [FIR_TAPS-1];                // Index 0 is the newest stored sample
  sample_t          win  [FIR_TAPS];                  // Window including the incoming sample
  logic [CNT_W-1:0] fill_cnt;
  fir_acc_t         acc;
  fir_acc_t         scaled;
  sample_t          sat_d;

  ////////////////////////////////////////////////////////////////////////////
  // Multiply-accumulate over the window
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    win[0] = data;
    for (int k = 1; k < FIR_TAPS; k++) begin
      win[k] = hist[k-1];
    end
  end

  always_comb begin
    acc = '0;
    for (int k = 0; k < FIR_TAPS; k++) begin
      acc = acc + fir_acc_t'(win[k]) * fir_acc_t'(FIR_COEFS[k]);
    end
    scaled = (acc + HALF_LSB) >>> FIR_SHIFT;          // Round half up, then drop fraction bits
    if (scaled > SAT_HI) begin
      sat_d = sample_t'(SAT_HI);
    end else if (scaled < SAT_LO) begin
      sat_d = sample_t'(SAT_LO);
    end else begin
      sat_d = sample_t'(scaled);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fill_cnt  <= '0;
      fir_valid <= 1'b0;
    end else begin
      // Output is only meaningful once every tap holds a real sample
      fir_valid <= data_valid && (fill_cnt >= CNT_W'(FIR_TAPS - 1));
      if (data_valid && (fill_cnt != CNT_W'(FIR_TAPS))) begin
        fill_cnt <= fill_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (data_valid) begin
      for (int k = 0; k < FIR_TAPS - 1; k++) begin
        hist[k] <= win[k];
      end
      fir_d <= sat_d;
    end
  end

  // A filter output always belongs to a strobe one cycle earlier on a full history
  a_valid_follows_strobe : assert property (
    @(posedge clk) disable iff (rst)
      fir_valid |-> $past(data_valid) && (fill_cnt == CNT_W'(FIR_TAPS))
  );

endmodule

// ==== verilog/fas_pkg.sv ====
// Spectrum front end shared types, widths, twiddle table and FIR coefficients
package fas_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sample path
  ////////////////////////////////////////////////////////////////////////////

  localparam int SAMPLE_W  = 16;                      // Q8.8 sample width
  localparam int COEF_W    = 18;                      // Q16 coefficient width
  localparam int ACC_W     = 40;                      // Holds the full sum of 32 products
  localparam int FIR_TAPS  = 32;
  localparam int FIR_SHIFT = 16;                      // Accumulator to sample scaling

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [COEF_W-1:0]   fir_coef_t;
  typedef logic signed [ACC_W-1:0]    fir_acc_t;

  // Symmetric low-pass coefficient set of FIR_TAPS entries
  `include "fir_coefficients.svh"

  ////////////////////////////////////////////////////////////////////////////
  // Transform path
  ////////////////////////////////////////////////////////////////////////////

  localparam int FFT_N      = 16;
  localparam int FFT_STAGES = 4;                      // log2 of FFT_N
  localparam int COMP_W     = 18;                     // Two guard bits above the sample
  localparam int TW_W       = 16;                     // Q14 twiddle width
  localparam int TW_SHIFT   = 14;

  typedef logic signed [COMP_W-1:0] fft_comp_t;
  typedef logic signed [TW_W-1:0]   twiddle_t;

  typedef struct packed {
    fft_comp_t re;
    fft_comp_t im;
  } bin_t;

  typedef sample_t [FFT_N-1:0] frame_t;               // Entry 0 is the oldest sample
  typedef bin_t    [FFT_N-1:0] bin_vec_t;

  // W16^k = cos(2*pi*k/16) - j*sin(2*pi*k/16), scaled by 16384 and rounded
  localparam twiddle_t TW_RE [FFT_N/2] = '{
    16'sd16384,  16'sd15137,  16'sd11585,  16'sd6270,
    16'sd0,     -16'sd6270,  -16'sd11585, -16'sd15137
  };

  localparam twiddle_t TW_IM [FFT_N/2] = '{
    16'sd0,     -16'sd6270,  -16'sd11585, -16'sd15137,
   -16'sd16384, -16'sd15137, -16'sd11585, -16'sd6270
  };

endpackage

// ==== verilog/fir_coefficients.svh ====
// FIR low-pass coefficient set in Q16, symmetric about the centre of the 32 taps
`ifndef FIR_COEFFICIENTS_SVH
`define FIR_COEFFICIENTS_SVH

// DC gain is just under unity, the absolute sum is about 1.42 so full-scale
// inputs with matching signs clip the output
localparam fir_coef_t FIR_COEFS [FIR_TAPS] = '{
  -18'sd96,
  -18'sd184,
  -18'sd232,
  -18'sd150,
   18'sd120,
   18'sd520,
   18'sd880,
   18'sd880,
   18'sd300,
  -18'sd820,
  -18'sd1960,
  -18'sd2460,
  -18'sd1320,
   18'sd4200,
   18'sd12600,
   18'sd19800,                                       // Centre pair
   18'sd19800,
   18'sd12600,
   18'sd4200,
  -18'sd1320,
  -18'sd2460,
  -18'sd1960,
  -18'sd820,
   18'sd300,
   18'sd880,
   18'sd880,
   18'sd520,
   18'sd120,
  -18'sd150,
  -18'sd232,
  -18'sd184,
  -18'sd96
};

`endif
